/* project.f */
bmx_pkg.sv
bank_rr_arb.sv
bank_grant_ctrl.sv
port_bank_mux.sv
bank_sram.sv
banked_mem_xbar.sv
tb_banked_mem_xbar.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the banked memory crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_banked_mem_xbar -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out="$(./obj_dir/sim_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

/* tb_banked_mem_xbar.sv */
/*
  self-checking testbench whose arbiter model assumes a round-robin ARB_POLICY
  every word is written once before the first read
*/
`timescale 1ns/10ps

module tb_banked_mem_xbar;

  localparam int NP = bmx_pkg::NUM_PORTS;
  localparam int NB = bmx_pkg::NUM_BANKS;
  localparam int DW = bmx_pkg::DATA_W;
  localparam int AW = bmx_pkg::ADDR_W;
  localparam int MW = bmx_pkg::MASK_W;
  localparam int MEM_WORDS = NB * bmx_pkg::BANK_WORDS;
  localparam int TIMEOUT = 50;

  logic                  clk_i = 1'b0;
  logic                  rst_i;
  logic [NP-1:0]         v_i;
  logic [NP-1:0]         w_i;
  logic [NP-1:0][AW-1:0] addr_i;
  logic [NP-1:0][DW-1:0] data_i;
  logic [NP-1:0][MW-1:0] mask_i;
  logic [NP-1:0]         yumi_o;
  logic [NP-1:0]         v_o;
  logic [NP-1:0][DW-1:0] data_o;

  logic [DW-1:0]         ref_mem [MEM_WORDS];
  int                    rr_ptr [NB];
  int                    wait_cnt [NP];
  logic [NP-1:0]         acc_q;
  logic [NP-1:0]         exp_v;
  logic [NP-1:0][DW-1:0] exp_d;
  logic                  started;
  logic                  timed_out;
  int                    value_errs;
  int                    other_errs;

  banked_mem_xbar banked_mem_xbar_inst (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .v_i   (v_i),
    .w_i   (w_i),
    .addr_i(addr_i),
    .data_i(data_i),
    .mask_i(mask_i),
    .yumi_o(yumi_o),
    .v_o   (v_o),
    .data_o(data_o)
  );

  always #4 clk_i = ~clk_i;

  // initial contents that differ for every address
  function automatic logic [DW-1:0] fill_word(logic [AW-1:0] a);
    return 32'h9E37_79B1 * (32'(a) + 32'd1);
  endfunction

  // mask bit 1 takes the byte from the new word
  function automatic logic [DW-1:0] merge_word(logic [DW-1:0] old_w, logic [DW-1:0] new_w,
                                               logic [MW-1:0] mask);
    logic [DW-1:0] res;
    res = old_w;
    for (int i = 0; i < MW; i++)
    begin
      if (mask[i])
        res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  // first requester after the last winner with wrap-around and -1 for no request
  function automatic int rr_pick(logic [NP-1:0] reqs, int last);
    int idx;
    for (int k = 1; k <= NP; k++)
    begin
      idx = (last + k) % NP;
      if (reqs[idx])
        return idx;
    end
    return -1;
  endfunction

  task automatic check_data(string name, logic [bmx_pkg::DATA_W-1:0] got,
                            logic [bmx_pkg::DATA_W-1:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
      value_errs++;
    end
  endtask

  always @(posedge clk_i)
  begin : compare_outputs
    logic [NP-1:0] reqs;
    logic [NP-1:0] exp_yumi;
    int            win;
    exp_yumi = '0;
    for (int b = 0; b < NB; b++)
    begin
      for (int p = 0; p < NP; p++)
        reqs[p] = v_i[p] && (int'(addr_i[p][AW-1 -: bmx_pkg::BANK_SEL_W]) == b);
      win = rr_pick(reqs, rr_ptr[b]);
      if (win >= 0)
      begin
        exp_yumi[win] = 1'b1;
        rr_ptr[b] = win;
      end
      if (rst_i)
        rr_ptr[b] = 0;
    end
    for (int p = 0; p < NP; p++)
    begin
      check_bit($sformatf("yumi_o[%0d]", p), yumi_o[p], exp_yumi[p]);
      if (started)
        check_bit($sformatf("v_o[%0d]", p), v_o[p], exp_v[p]);
      if (started && exp_v[p])
        check_data($sformatf("data_o[%0d]", p), data_o[p], exp_d[p]);
      // a held request loses at most NP-1 times in a row
      if (v_i[p] && !yumi_o[p])
        wait_cnt[p]++;
      else
        wait_cnt[p] = 0;
      if (wait_cnt[p] >= NP)
      begin
        $display("port %0d was not accepted within %0d cycles at t=%0t", p, NP, $time);
        other_errs++;
        wait_cnt[p] = 0;
      end
    end
    // reads see the memory before this cycle's writes
    for (int p = 0; p < NP; p++)
    begin
      exp_v[p] = exp_yumi[p] && !w_i[p] && !rst_i;
      exp_d[p] = ref_mem[addr_i[p]];
    end
    for (int p = 0; p < NP; p++)
    begin
      if (exp_yumi[p] && w_i[p])
        ref_mem[addr_i[p]] = merge_word(ref_mem[addr_i[p]], data_i[p], mask_i[p]);
    end
    acc_q = yumi_o;
    if (rst_i)
      started = 1'b1;
  end

  task automatic set_req(int p, logic w, logic [AW-1:0] a, logic [DW-1:0] d, logic [MW-1:0] m);
    v_i[p]    = 1'b1;
    w_i[p]    = w;
    addr_i[p] = a;
    data_i[p] = d;
    mask_i[p] = m;
  endtask

  // hold requests until accepted and idle each port after that
  task automatic wait_accept(string what);
    int cycles;
    cycles = 0;
    while (v_i != '0 && cycles <= TIMEOUT)
    begin
      @(negedge clk_i);
      v_i = v_i & ~acc_q;
      cycles++;
    end
    if (v_i != '0)
    begin
      $display("timeout: requests never accepted during %s", what);
      other_errs++;
      timed_out = 1'b1;
    end
  endtask

  // all ports hit distinct banks so every cycle accepts all of them
  task automatic fill_memory();
    logic [AW-1:0] a;
    for (int i = 0; i < bmx_pkg::BANK_WORDS && !timed_out; i++)
    begin
      for (int p = 0; p < NP; p++)
      begin
        a = AW'(((p + i) % NB) * bmx_pkg::BANK_WORDS + i);
        set_req(p, 1'b1, a, fill_word(a), '1);
      end
      wait_accept("memory fill");
    end
  endtask

  task automatic masked_rw();
    logic [AW-1:0] a;
    for (int p = 0; p < NP && !timed_out; p++)
    begin
      a = AW'(p * 17 + 3);
      set_req(p, 1'b1, a, DW'($urandom), MW'(p * 3 + 5));
      wait_accept("masked write");
      if (!timed_out)
      begin
        set_req((p + 1) % NP, 1'b0, a, '0, '0);
        wait_accept("read after write");
      end
    end
  endtask

  // every port on bank 2 with the pointer deciding the order
  task automatic contention();
    for (int r = 0; r < 3 && !timed_out; r++)
    begin
      for (int p = 0; p < NP; p++)
        set_req(p, 1'(p + r), AW'(2 * bmx_pkg::BANK_WORDS + p * 3 + r), DW'($urandom), '1);
      wait_accept("single bank contention");
    end
  endtask

  task automatic random_traffic();
    for (int c = 0; c < 400; c++)
    begin
      @(negedge clk_i);
      for (int p = 0; p < NP; p++)
      begin
        if (!v_i[p] || acc_q[p])
        begin
          if ($urandom_range(3) != 0)
            set_req(p, 1'($urandom_range(1)), AW'($urandom), DW'($urandom), MW'($urandom));
          else
            v_i[p] = 1'b0;
        end
      end
    end
    wait_accept("random traffic drain");
  endtask

  task automatic end_run();
    $display("value errors %0d, other errors %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  endtask

  initial
  begin
    void'($urandom(13035));
    rst_i      = 1'b1;
    v_i        = '0;
    w_i        = '0;
    addr_i     = '0;
    data_i     = '0;
    mask_i     = '0;
    acc_q      = '0;
    exp_v      = '0;
    started    = 1'b0;
    timed_out  = 1'b0;
    value_errs = 0;
    other_errs = 0;
    for (int p = 0; p < NP; p++)
      wait_cnt[p] = 0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    // idle right after reset
    repeat (2) @(negedge clk_i);
    fill_memory();
    if (!timed_out)
      masked_rw();
    if (!timed_out)
      contention();
    if (!timed_out)
      random_traffic();
    // last read returns one cycle after acceptance
    repeat (2) @(negedge clk_i);
    end_run();
  end

endmodule

/* banked_mem_xbar.sv */
/*
  banked scratchpad shared by NUM_PORTS requesters with same-cycle yumi_o
  hold a request until yumi_o; read data returns one cycle after acceptance
*/
`timescale 1ns/10ps

module banked_mem_xbar (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic [bmx_pkg::NUM_PORTS-1:0]                     v_i,
  input  logic [bmx_pkg::NUM_PORTS-1:0]                     w_i,
  input  logic [bmx_pkg::NUM_PORTS-1:0][bmx_pkg::ADDR_W-1:0] addr_i,
  input  logic [bmx_pkg::NUM_PORTS-1:0][bmx_pkg::DATA_W-1:0] data_i,
  input  logic [bmx_pkg::NUM_PORTS-1:0][bmx_pkg::MASK_W-1:0] mask_i,
  output logic [bmx_pkg::NUM_PORTS-1:0]                     yumi_o,
  output logic [bmx_pkg::NUM_PORTS-1:0]                     v_o,
  output logic [bmx_pkg::NUM_PORTS-1:0][bmx_pkg::DATA_W-1:0] data_o
);

  localparam int NP  = bmx_pkg::NUM_PORTS;
  localparam int NB  = bmx_pkg::NUM_BANKS;
  localparam int RTW = bmx_pkg::DATA_W + 1;

  logic [NP-1:0][bmx_pkg::BANK_SEL_W-1:0]  port_sel;
  logic [NP-1:0][bmx_pkg::BANK_ADDR_W-1:0] port_addr;

  logic [NB-1:0][NP-1:0]                   grants;
  logic [NB-1:0][NP-1:0]                   grants_q;
  logic [NP-1:0][NB-1:0]                   port_grants_q;
  logic [NB-1:0]                           bank_v;
  logic [NB-1:0]                           bank_w;
  logic [NB-1:0]                           rd_q;

  logic [NB-1:0][bmx_pkg::BANK_ADDR_W-1:0] bank_addr;
  logic [NB-1:0][bmx_pkg::DATA_W-1:0]      bank_wdata;
  logic [NB-1:0][bmx_pkg::MASK_W-1:0]      bank_mask;
  logic [NB-1:0][bmx_pkg::DATA_W-1:0]      bank_rdata;

  // read flag travels with the data back to the port
  logic [NB-1:0][RTW-1:0]                  bank_ret;
  logic [NP-1:0][RTW-1:0]                  port_ret;

  genvar p, b;

  for (p = 0; p < NP; p++)
  begin : g_port
    assign port_sel[p]  = addr_i[p][bmx_pkg::BANK_ADDR_W +: bmx_pkg::BANK_SEL_W];
    assign port_addr[p] = addr_i[p][0 +: bmx_pkg::BANK_ADDR_W];
    assign v_o[p]       = port_ret[p][bmx_pkg::DATA_W];
    assign data_o[p]    = port_ret[p][bmx_pkg::DATA_W-1:0];
  end

  bank_grant_ctrl #(
    .POLICY(bmx_pkg::ARB_POLICY)
  ) bank_grant_ctrl_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .v_i       (v_i),
    .bank_sel_i(port_sel),
    .yumi_o    (yumi_o),
    .bank_v_o  (bank_v),
    .grants_o  (grants)
  );

  // ports to banks
  port_bank_mux #(.SRC(NP), .DST(NB), .WIDTH(bmx_pkg::BANK_ADDR_W)) addr_mux_inst (
    .i_i(port_addr), .sel_i(grants), .o_o(bank_addr)
  );

  port_bank_mux #(.SRC(NP), .DST(NB), .WIDTH(bmx_pkg::DATA_W)) data_mux_inst (
    .i_i(data_i), .sel_i(grants), .o_o(bank_wdata)
  );

  port_bank_mux #(.SRC(NP), .DST(NB), .WIDTH(1)) w_mux_inst (
    .i_i(w_i), .sel_i(grants), .o_o(bank_w)
  );

  port_bank_mux #(.SRC(NP), .DST(NB), .WIDTH(bmx_pkg::MASK_W)) mask_mux_inst (
    .i_i(mask_i), .sel_i(grants), .o_o(bank_mask)
  );

  for (b = 0; b < NB; b++)
  begin : g_bank
    bank_sram bank_sram_inst (
      .clk_i (clk_i),
      .v_i   (bank_v[b]),
      .w_i   (bank_w[b]),
      .addr_i(bank_addr[b]),
      .data_i(bank_wdata[b]),
      .mask_i(bank_mask[b]),
      .data_o(bank_rdata[b])
    );

    assign bank_ret[b] = {rd_q[b], bank_rdata[b]};

    for (p = 0; p < NP; p++)
    begin : g_xpose
      assign port_grants_q[p][b] = grants_q[b][p];
    end
  end

  // remember who owns each bank's read data next cycle
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      grants_q <= '0;
      rd_q     <= '0;
    end
    else
    begin
      grants_q <= grants;
      rd_q     <= bank_v & ~bank_w;
    end
  end

  // banks back to ports
  port_bank_mux #(.SRC(NB), .DST(NP), .WIDTH(RTW)) ret_mux_inst (
    .i_i(bank_ret), .sel_i(port_grants_q), .o_o(port_ret)
  );

endmodule

/* bank_sram.sv */
/*
  single-port synchronous bank with byte-masked write and no reset of contents
  read data appears the cycle after v_i and holds until the next read
*/
`timescale 1ns/10ps

module bank_sram (
  input  logic                            clk_i,
  input  logic                            v_i,
  input  logic                            w_i,
  input  logic [bmx_pkg::BANK_ADDR_W-1:0] addr_i,
  input  logic [bmx_pkg::DATA_W-1:0]      data_i,
  input  logic [bmx_pkg::MASK_W-1:0]      mask_i,
  output logic [bmx_pkg::DATA_W-1:0]      data_o
);

  logic [bmx_pkg::DATA_W-1:0] mem [bmx_pkg::BANK_WORDS];

  always_ff @(posedge clk_i)
  begin
    if (v_i)
    begin
      if (w_i)
      begin
        // only enabled bytes are written
        for (int i = 0; i < bmx_pkg::MASK_W; i++)
        begin
          if (mask_i[i])
            mem[addr_i][8*i +: 8] <= data_i[8*i +: 8];
        end
      end
      else
      begin
        data_o <= mem[addr_i];
      end
    end
  end

endmodule

/* port_bank_mux.sv */
/*
  one-hot AND-OR crossbar where sel_i holds at most one bit per destination
  a destination with no selected source reads zero
*/
`timescale 1ns/10ps

module port_bank_mux #(
  parameter int SRC   = 4,
  parameter int DST   = 4,
  parameter int WIDTH = 32
) (
  input  logic [SRC-1:0][WIDTH-1:0] i_i,
  input  logic [DST-1:0][SRC-1:0]   sel_i,
  output logic [DST-1:0][WIDTH-1:0] o_o
);

  always_comb
  begin
    for (int d = 0; d < DST; d++)
    begin
      o_o[d] = '0;
      for (int s = 0; s < SRC; s++)
      begin
        // each selected source is ORed in
        o_o[d] = o_o[d] | (i_i[s] & {WIDTH{sel_i[d][s]}});
      end
    end
  end

endmodule

/* bank_grant_ctrl.sv */
/*
  turns port bank selects into per-bank requests and arbitrates each bank
  banks are always ready, so a grant is also an acceptance
*/
`timescale 1ns/10ps

module bank_grant_ctrl #(
  parameter bmx_pkg::arb_policy_e POLICY = bmx_pkg::ARB_POLICY
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  logic [bmx_pkg::NUM_PORTS-1:0]                         v_i,
  input  logic [bmx_pkg::NUM_PORTS-1:0][bmx_pkg::BANK_SEL_W-1:0] bank_sel_i,
  output logic [bmx_pkg::NUM_PORTS-1:0]                         yumi_o,
  output logic [bmx_pkg::NUM_BANKS-1:0]                         bank_v_o,
  output logic [bmx_pkg::NUM_BANKS-1:0][bmx_pkg::NUM_PORTS-1:0] grants_o
);

  // port view and bank view of requests and grants
  logic [bmx_pkg::NUM_PORTS-1:0][bmx_pkg::NUM_BANKS-1:0] req_pb;
  logic [bmx_pkg::NUM_BANKS-1:0][bmx_pkg::NUM_PORTS-1:0] req_bp;
  logic [bmx_pkg::NUM_PORTS-1:0][bmx_pkg::NUM_BANKS-1:0] grant_pb;

  genvar p, b;

  for (p = 0; p < bmx_pkg::NUM_PORTS; p++)
  begin : g_port
    // one-hot bank request that is empty for an idle port
    assign req_pb[p] = v_i[p] ? (bmx_pkg::NUM_BANKS)'(1 << bank_sel_i[p])
                              : '0;
    assign yumi_o[p] = v_i[p] & (|grant_pb[p]);
  end

  for (b = 0; b < bmx_pkg::NUM_BANKS; b++)
  begin : g_bank
    for (p = 0; p < bmx_pkg::NUM_PORTS; p++)
    begin : g_xpose
      assign req_bp[b][p]   = req_pb[p][b];
      assign grant_pb[p][b] = grants_o[b][p];
    end

    bank_rr_arb #(
      .POLICY(POLICY)
    ) bank_rr_arb_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .reqs_i  (req_bp[b]),
      .grants_o(grants_o[b]),
      .v_o     (bank_v_o[b])
    );
  end

endmodule

/* bank_rr_arb.sv */
/*
  per-bank arbiter with a grant that is combinational from reqs_i
  round-robin pointer holds the last granted port and is cleared by reset
*/
`timescale 1ns/10ps

module bank_rr_arb #(
  parameter bmx_pkg::arb_policy_e POLICY = bmx_pkg::ARB_POLICY
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [bmx_pkg::NUM_PORTS-1:0] reqs_i,
  output logic [bmx_pkg::NUM_PORTS-1:0] grants_o,
  output logic                          v_o
);

  logic [bmx_pkg::PORT_SEL_W-1:0] last_q;
  logic [bmx_pkg::PORT_SEL_W-1:0] win_idx;

  always_comb
  begin : arb_comb
    int   idx;
    logic found;
    grants_o = '0;
    win_idx  = last_q;
    found    = 1'b0;
    idx      = 0;
    case (POLICY)
      bmx_pkg::ARB_FIXED_LO:
      begin
        for (int i = 0; i < bmx_pkg::NUM_PORTS; i++)
        begin
          if (reqs_i[i] && !found)
          begin
            grants_o[i] = 1'b1;
            win_idx     = bmx_pkg::PORT_SEL_W'(i);
            found       = 1'b1;
          end
        end
      end
      bmx_pkg::ARB_FIXED_HI:
      begin
        for (int i = bmx_pkg::NUM_PORTS - 1; i >= 0; i--)
        begin
          if (reqs_i[i] && !found)
          begin
            grants_o[i] = 1'b1;
            win_idx     = bmx_pkg::PORT_SEL_W'(i);
            found       = 1'b1;
          end
        end
      end
      default:
      begin
        // search starts one past the last winner and wraps
        for (int k = 1; k <= bmx_pkg::NUM_PORTS; k++)
        begin
          idx = (int'(last_q) + k) % bmx_pkg::NUM_PORTS;
          if (reqs_i[idx] && !found)
          begin
            grants_o[idx] = 1'b1;
            win_idx       = bmx_pkg::PORT_SEL_W'(idx);
            found         = 1'b1;
          end
        end
      end
    endcase
  end

  assign v_o = |grants_o;

  // pointer advances only on a cycle with a grant
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      last_q <= '0;
    else if (v_o)
      last_q <= win_idx;
  end

endmodule

/* bmx_pkg.sv */
/*
  sizes and arbitration policy shared by the banked memory crossbar
  NUM_BANKS, BANK_WORDS and NUM_PORTS are expected to be powers of two
*/
package bmx_pkg;

  // requesters and banks
  localparam int NUM_PORTS  = 4;
  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 16;

  // data path
  localparam int DATA_W = 32;
  localparam int MASK_W = DATA_W / 8;

  // bank select sits in the high-order address bits
  localparam int BANK_SEL_W  = $clog2(NUM_BANKS);
  localparam int BANK_ADDR_W = $clog2(BANK_WORDS);
  localparam int ADDR_W      = BANK_SEL_W + BANK_ADDR_W;

  // port index width for the round-robin pointer
  localparam int PORT_SEL_W = $clog2(NUM_PORTS);

  // bank arbitration policy chosen at elaboration
  typedef enum logic [1:0] {
    ARB_FIXED_LO,
    ARB_FIXED_HI,
    ARB_ROUND_ROBIN
  } arb_policy_e;

  localparam arb_policy_e ARB_POLICY = ARB_ROUND_ROBIN;

endpackage
